// File: build.f
hw/core_pkg.sv
hw/mul_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/int_core.sv
verif/tb_int_core.sv

// File: hw/core_pkg.sv
package core_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes of the supported classes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Same instruction word, register or immediate view
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic {
        FU_ALU,
        FU_MUL
    } func_unit_e;

endpackage

// File: hw/decode_stage.sv
module decode_stage #(
    parameter int XLEN = 32
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            instr_valid,
    output logic                            instr_ready,
    input  core_pkg::instr_t                instr,
    output logic                            illegal,
    output logic                            de_valid,
    input  logic                            de_ready,
    output core_pkg::alu_op_e               de_op,
    output core_pkg::func_unit_e            de_unit,
    output logic [core_pkg::REG_ADDR_W-1:0] de_rs1,
    output logic [core_pkg::REG_ADDR_W-1:0] de_rs2,
    output logic [core_pkg::REG_ADDR_W-1:0] de_rd,
    output logic                            de_use_imm,
    output logic [XLEN-1:0]                 de_imm
);
    import core_pkg::*;

    logic    is_op;
    logic    is_imm;
    logic    is_mul;
    logic    is_shift;
    logic    alt;
    logic    shamt_ok;
    logic    shift_ok;
    logic    legal;
    logic    accept;
    alu_op_e op;

    assign is_op    = instr.r.opcode == OPC_OP;
    assign is_imm   = instr.i.opcode == OPC_OP_IMM;
    assign is_mul   = is_op && instr.r.funct7 == 7'b0000001 && instr.r.funct3 == 3'b000;
    assign is_shift = instr.i.funct3[1:0] == 2'b01;

    // SUB and SRA select bit sits at bit 30 in both formats
    assign alt = instr.r.funct7[5];

    // Shift amount bit 5 only exists on 64-bit cores
    assign shamt_ok = (XLEN == 64) || !instr.i.imm12[5];
    assign shift_ok = shamt_ok && (instr.i.imm12[11:6] == 6'b000000 ||
                      (instr.i.imm12[11:6] == 6'b010000 && instr.i.funct3 == 3'b101));

    assign legal = (is_op && (is_mul || instr.r.funct7 == 7'b0000000 ||
                   (instr.r.funct7 == 7'b0100000 && instr.r.funct3 inside {3'b000, 3'b101})))
                   || (is_imm && (!is_shift || shift_ok));

    always_comb begin
        case (instr.r.funct3)
            3'b000:  op = (is_op && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
    end

    assign instr_ready = !de_valid || de_ready;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            de_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            // Rejected words never occupy the decode register
            illegal <= accept && !legal;
            if (accept && legal) begin
                de_valid <= 1'b1;
            end else if (de_ready) begin
                de_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && legal) begin
            de_op      <= op;
            de_unit    <= is_mul ? FU_MUL : FU_ALU;
            de_rs1     <= instr.r.rs1;
            de_rs2     <= instr.r.rs2;
            de_rd      <= instr.r.rd;
            de_use_imm <= is_imm;
            de_imm     <= {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
        end
    end

    // A stalled entry stays put until execute takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        de_valid && !de_ready |=> de_valid && $stable(de_rd));

endmodule

// File: hw/execute_stage.sv
module execute_stage #(
    parameter int XLEN = 32
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            de_valid,
    output logic                            de_ready,
    input  core_pkg::alu_op_e               de_op,
    input  core_pkg::func_unit_e            de_unit,
    input  logic [core_pkg::REG_ADDR_W-1:0] de_rs1,
    input  logic [core_pkg::REG_ADDR_W-1:0] de_rs2,
    input  logic [core_pkg::REG_ADDR_W-1:0] de_rd,
    input  logic                            de_use_imm,
    input  logic [XLEN-1:0]                 de_imm,
    input  logic [XLEN-1:0]                 rs1_value,
    input  logic [XLEN-1:0]                 rs2_value,
    output logic                            wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]                 wb_data
);
    import core_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic                  ex1_pending_q;
    func_unit_e            ex1_unit_q;
    logic [XLEN-1:0]       ex1_data_q;
    logic [REG_ADDR_W-1:0] ex1_rd_q;
    logic                  ex1_data_valid;
    logic [XLEN-1:0]       ex1_data;
    logic                  ex1_ready;

    logic                  ex2_pending_q;
    func_unit_e            ex2_unit_q;
    logic [XLEN-1:0]       ex2_data_q;
    logic [REG_ADDR_W-1:0] ex2_rd_q;
    logic                  ex2_data_valid;
    logic [XLEN-1:0]       ex2_data;
    logic                  ex2_ready;

    logic [XLEN-1:0]       rs1_fwd;
    logic [XLEN-1:0]       rs2_fwd;
    logic                  data_hazard;
    logic                  struct_hazard;
    logic                  issue;

    logic                  mul_start;
    logic                  mul_busy;
    logic                  mul_done;
    logic [XLEN-1:0]       mul_result;

    ////////////////////
    // Bypass and hazards
    ////////////////////

    // EX1 holds the younger result, so it overrides EX2
    function automatic logic [XLEN-1:0] fwd_value(input logic [REG_ADDR_W-1:0] idx,
                                                  input logic [XLEN-1:0] rf_value);
        logic [XLEN-1:0] value;
        value = rf_value;
        if (ex2_pending_q && ex2_rd_q == idx && idx != '0) begin
            value = ex2_data;
        end
        if (ex1_pending_q && ex1_rd_q == idx && idx != '0) begin
            value = ex1_data;
        end
        return value;
    endfunction

    // Source waits on a multiply that has not finished
    function automatic logic blocked(input logic [REG_ADDR_W-1:0] idx);
        return idx != '0 && ((ex1_pending_q && ex1_rd_q == idx && !ex1_data_valid) ||
                             (ex2_pending_q && ex2_rd_q == idx && !ex2_data_valid));
    endfunction

    always_comb begin
        rs1_fwd     = fwd_value(de_rs1, rs1_value);
        rs2_fwd     = fwd_value(de_rs2, rs2_value);
        data_hazard = blocked(de_rs1) || (!de_use_imm && blocked(de_rs2));
    end

    assign struct_hazard = !ex1_ready || (de_unit == FU_MUL && mul_busy);
    assign de_ready      = !data_hazard && !struct_hazard;
    assign issue         = de_valid && de_ready;
    assign mul_start     = issue && de_unit == FU_MUL;

    ////////////////////
    // ALU
    ////////////////////

    logic [XLEN-1:0]    operand_b;
    logic [XLEN:0]      diff_ext;
    logic               less_signed;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_result;

    assign operand_b = de_use_imm ? de_imm : rs2_fwd;
    // Extra top bit of the difference is the unsigned borrow
    assign diff_ext  = {1'b0, rs1_fwd} - {1'b0, operand_b};
    assign less_signed = (rs1_fwd[XLEN-1] != operand_b[XLEN-1]) ? rs1_fwd[XLEN-1]
                                                                : diff_ext[XLEN-1];
    assign shamt = operand_b[SHAMT_W-1:0];

    always_comb begin
        case (de_op)
            ALU_ADD:  alu_result = rs1_fwd + operand_b;
            ALU_SUB:  alu_result = diff_ext[XLEN-1:0];
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, less_signed};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, diff_ext[XLEN]};
            ALU_XOR:  alu_result = rs1_fwd ^ operand_b;
            ALU_OR:   alu_result = rs1_fwd | operand_b;
            ALU_AND:  alu_result = rs1_fwd & operand_b;
            ALU_SLL:  alu_result = rs1_fwd << shamt;
            ALU_SRL:  alu_result = rs1_fwd >> shamt;
            ALU_SRA:  alu_result = $signed(rs1_fwd) >>> shamt;
            default:  alu_result = '0;
        endcase
    end

    ////////////////////
    // EX1 and EX2
    ////////////////////

    // Only one multiply is ever in flight, so mul_done belongs to whichever stage holds it
    assign ex1_data_valid = ex1_unit_q == FU_ALU || mul_done;
    assign ex1_data       = (ex1_unit_q == FU_ALU) ? ex1_data_q : mul_result;
    assign ex2_data_valid = ex2_unit_q == FU_ALU || mul_done;
    assign ex2_data       = (ex2_unit_q == FU_ALU) ? ex2_data_q : mul_result;

    assign ex2_ready = !ex2_pending_q || ex2_data_valid;
    assign ex1_ready = !ex1_pending_q || ex2_ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_pending_q <= 1'b0;
            ex1_unit_q    <= FU_ALU;
            ex2_pending_q <= 1'b0;
            ex2_unit_q    <= FU_ALU;
        end else begin
            // A finished product is parked as plain data
            if (ex1_data_valid || ex2_ready) begin
                ex1_unit_q <= FU_ALU;
            end
            if (ex2_ready) begin
                ex1_pending_q <= 1'b0;
            end
            if (issue) begin
                ex1_pending_q <= 1'b1;
                ex1_unit_q    <= de_unit;
            end
            if (ex2_data_valid) begin
                ex2_pending_q <= 1'b0;
                ex2_unit_q    <= FU_ALU;
            end
            if (ex1_pending_q && ex2_ready) begin
                ex2_pending_q <= 1'b1;
                ex2_unit_q    <= ex1_data_valid ? FU_ALU : ex1_unit_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            ex1_data_q <= alu_result;
            ex1_rd_q   <= de_rd;
        end else if (ex1_data_valid) begin
            ex1_data_q <= ex1_data;
        end
        if (ex1_pending_q && ex2_ready) begin
            ex2_data_q <= ex1_data;
            ex2_rd_q   <= ex1_rd_q;
        end
    end

    assign wb_valid = ex2_pending_q && ex2_data_valid;
    assign wb_rd    = ex2_rd_q;
    assign wb_data  = ex2_data;

    mul_unit #(
        .XLEN (XLEN)
    ) mul_unit_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .mul_start  (mul_start),
        .operand_a  (rs1_fwd),
        .operand_b  (rs2_fwd),
        .mul_busy   (mul_busy),
        .mul_done   (mul_done),
        .mul_result (mul_result)
    );

    // Back-to-back commits need EX1 to refill EX2 in between
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_valid |=> !wb_valid || $past(ex1_pending_q));

endmodule

// File: hw/int_core.sv
module int_core #(
    parameter int XLEN = 32
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            instr_valid,
    output logic                            instr_ready,
    input  core_pkg::instr_t                instr,
    output logic                            illegal,
    output logic                            retire_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [XLEN-1:0]                 retire_data
);
    import core_pkg::*;

    // Decode register outputs
    logic                  de_valid;
    logic                  de_ready;
    alu_op_e               de_op;
    func_unit_e            de_unit;
    logic [REG_ADDR_W-1:0] de_rs1;
    logic [REG_ADDR_W-1:0] de_rs2;
    logic [REG_ADDR_W-1:0] de_rd;
    logic                  de_use_imm;
    logic [XLEN-1:0]       de_imm;

    // Register file and commit
    logic [XLEN-1:0]       rs1_value;
    logic [XLEN-1:0]       rs2_value;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    decode_stage #(
        .XLEN (XLEN)
    ) decode_stage_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .illegal     (illegal),
        .de_valid    (de_valid),
        .de_ready    (de_ready),
        .de_op       (de_op),
        .de_unit     (de_unit),
        .de_rs1      (de_rs1),
        .de_rs2      (de_rs2),
        .de_rd       (de_rd),
        .de_use_imm  (de_use_imm),
        .de_imm      (de_imm)
    );

    execute_stage #(
        .XLEN (XLEN)
    ) execute_stage_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .de_valid   (de_valid),
        .de_ready   (de_ready),
        .de_op      (de_op),
        .de_unit    (de_unit),
        .de_rs1     (de_rs1),
        .de_rs2     (de_rs2),
        .de_rd      (de_rd),
        .de_use_imm (de_use_imm),
        .de_imm     (de_imm),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    // Sources are read straight from the decode register
    result_stage #(
        .XLEN (XLEN)
    ) result_stage_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .rs1_addr     (de_rs1),
        .rs2_addr     (de_rs2),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

// File: hw/mul_unit.sv
module mul_unit #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            mul_start,
    input  logic [XLEN-1:0] operand_a,
    input  logic [XLEN-1:0] operand_b,
    output logic            mul_busy,
    output logic            mul_done,
    output logic [XLEN-1:0] mul_result
);
    localparam int CNT_W = $clog2(XLEN + 1);

    logic [CNT_W-1:0] count_q;
    logic [XLEN-1:0]  multiplicand_q;
    logic [XLEN-1:0]  multiplier_q;
    logic [XLEN-1:0]  acc_q;

    assign mul_busy   = count_q != '0;
    assign mul_result = acc_q;

    // One multiplier bit per cycle, done strobe after the last step
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q  <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= count_q == CNT_W'(1);
            if (mul_start) begin
                count_q <= CNT_W'(XLEN);
            end else if (mul_busy) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mul_start) begin
            multiplicand_q <= operand_a;
            multiplier_q   <= operand_b;
            acc_q          <= '0;
        end else if (mul_busy) begin
            if (multiplier_q[0]) begin
                acc_q <= acc_q + multiplicand_q;
            end
            multiplicand_q <= multiplicand_q << 1;
            multiplier_q   <= multiplier_q >> 1;
        end
    end

    // Execute must hold a MUL back while a product is being formed
    assert property (@(posedge clk_i) disable iff (!rst_ni) mul_start |-> !mul_busy);

endmodule

// File: hw/result_stage.sv
module result_stage #(
    parameter int XLEN = 32
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]                 rs1_value,
    output logic [XLEN-1:0]                 rs2_value,
    input  logic                            wb_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]                 wb_data,
    output logic                            retire_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [XLEN-1:0]                 retire_data
);
    import core_pkg::*;

    // No storage for x0
    logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];

    assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk_i) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
        if (wb_valid) begin
            retire_rd   <= wb_rd;
            retire_data <= wb_data;
        end
    end

    // Commits to x0 are still reported
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_valid;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_int_core -f build.f -o sim_int_core

out=$(./obj_dir/sim_int_core)
echo "$out"
echo "$out" | grep -q "Everything OK"

// File: verif/int_core_stimulus.txt
// Columns (hex): tag, instruction word, expected rd, expected retire data
// Tag 1 retires rd with data, tag 2 is an illegal word, tag 0 ends the list
1 00500093 01 00000005
1 FFD00113 02 FFFFFFFD
1 002081B3 03 00000002
1 40208233 04 00000008
1 001122B3 05 00000001
1 00113333 06 00000000
1 0020C3B3 07 FFFFFFF8
1 0020E433 08 FFFFFFFD
1 0020F4B3 09 00000005
1 00109533 0A 000000A0
1 001155B3 0B 07FFFFFF
1 40115633 0C FFFFFFFF
2 FFFFFFFF 00 00000000
1 FFF0C693 0D FFFFFFFA
1 FFE12713 0E 00000001
1 FFF0B793 0F 00000001
1 7FF06813 10 000007FF
1 0F087893 11 000000F0
1 00489913 12 00000F00
1 01C15993 13 0000000F
1 40115A13 14 FFFFFFFE
2 02009093 00 00000000
2 4020C3B3 00 00000000
2 02109533 00 00000000
1 02208AB3 15 FFFFFFF1
1 001A8B33 16 FFFFFFF6
1 036B0BB3 17 00000064
1 030B8C33 18 00031F9C
1 417C0CB3 19 00031F38
1 00708013 00 0000000C
1 00000D33 1A 00000000
1 02738DB3 1B 00000040
1 03080E33 1C 003FF001
1 03010EB3 1D FFFFE803
1 01CECF33 1E FFC01802
0 00000000 00 00000000

// File: verif/tb_int_core.sv
module tb_int_core;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int XLEN        = 32;
    localparam int MAX_ENTRIES = 64;
    localparam int TIMEOUT     = 200;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  instr_valid;
    logic                  instr_ready;
    instr_t                instr;
    logic                  illegal;
    logic                  retire_valid;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_data;

    // Four words per entry: tag, instruction, rd, data
    logic [31:0]           stim_mem [0:4*MAX_ENTRIES-1];
    logic [16:0]           lfsr_state;

    // Expected retire entries in acceptance order
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0]       exp_data_q [$];
    int                    exp_entry_q [$];

    int retire_errors    = 0;
    int illegal_errors   = 0;
    int timeout_errors   = 0;
    int illegal_expected = 0;
    int illegal_seen     = 0;
    int retire_count     = 0;

    int_core #(
        .XLEN (XLEN)
    ) int_core_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .illegal      (illegal),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Taps 17 and 14, maximal length
    function automatic logic [16:0] lfsr_next(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    // Two LFSR bits give an idle gap of 0 to 3 cycles
    task automatic draw_gap(output logic [1:0] gap);
        lfsr_state = lfsr_next(lfsr_state);
        gap[0]     = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        gap[1]     = lfsr_state[0];
    endtask

    task automatic check_retire(input string                 name,
                                input logic [REG_ADDR_W-1:0] exp_rd,
                                input logic [REG_ADDR_W-1:0] act_rd,
                                input logic [XLEN-1:0]       exp_data,
                                input logic [XLEN-1:0]       act_data);
        if (act_rd !== exp_rd) begin
            retire_errors++;
            $display("Error %s rd: expected x%0d, actual x%0d", name, exp_rd, act_rd);
        end
        if (act_data !== exp_data) begin
            retire_errors++;
            $display("Error %s data: expected 0x%h, actual 0x%h", name, exp_data, act_data);
        end
    endtask

    task automatic check_illegal(input string name, input int expected, input int actual);
        if (actual != expected) begin
            illegal_errors++;
            $display("Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    ////////////////////
    // Retire monitor
    ////////////////////

    // Outputs are registered, so the falling edge sees settled values
    initial begin
        forever begin
            @(negedge clk_i);
            if (rst_ni) begin
                if (illegal) begin
                    illegal_seen++;
                end
                if (retire_valid && exp_rd_q.size() == 0) begin
                    retire_errors++;
                    $display("Retire of x%0d seen with no instruction outstanding", retire_rd);
                end else if (retire_valid) begin
                    retire_count++;
                    check_retire($sformatf("retire %0d (entry %0d)", retire_count,
                                           exp_entry_q[0]),
                                 exp_rd_q[0], retire_rd, exp_data_q[0], retire_data);
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_entry_q.pop_front());
                end
            end
        end
    end

    ////////////////////
    // Driver
    ////////////////////

    initial begin
        int          k;
        int          base;
        int          waited;
        logic [1:0]  gap;
        logic [31:0] tag;
        bit          aborted;

        instr_valid = 1'b0;
        instr       = '0;
        rst_ni      = 1'b0;
        lfsr_state  = 17'd71177;
        aborted     = 1'b0;
        $readmemh("verif/int_core_stimulus.txt", stim_mem);

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        for (k = 0; k < MAX_ENTRIES && !aborted; k++) begin
            base = 4 * k;
            tag  = stim_mem[base];
            if (tag !== 32'h1 && tag !== 32'h2) begin
                break;
            end
            draw_gap(gap);
            repeat (gap) @(negedge clk_i);
            instr_valid = 1'b1;
            instr       = instr_t'(stim_mem[base + 1][INSTR_W-1:0]);
            waited      = 0;
            while (!instr_ready && waited < TIMEOUT) begin
                @(negedge clk_i);
                waited++;
            end
            if (!instr_ready) begin
                timeout_errors++;
                $display("Timeout: entry %0d was never accepted by the core", k);
                aborted = 1'b1;
            end else begin
                // Ready is high, so the word transfers on the coming rising edge
                if (tag == 32'h1) begin
                    exp_rd_q.push_back(stim_mem[base + 2][REG_ADDR_W-1:0]);
                    exp_data_q.push_back(stim_mem[base + 3][XLEN-1:0]);
                    exp_entry_q.push_back(k);
                end else begin
                    illegal_expected++;
                end
                @(negedge clk_i);
            end
            instr_valid = 1'b0;
        end

        waited = 0;
        while (!aborted && exp_rd_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!aborted && exp_rd_q.size() != 0) begin
            timeout_errors++;
            $display("Timeout: %0d instructions never retired", exp_rd_q.size());
        end

        // Quiet window to catch stray retire or illegal pulses
        repeat (4) @(negedge clk_i);
        check_illegal("illegal pulses", illegal_expected, illegal_seen);

        $display("Errors: retire %0d, illegal %0d, timeout %0d",
                 retire_errors, illegal_errors, timeout_errors);
        if (retire_errors + illegal_errors + timeout_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
